// File: include/rst_defs.svh
// Reset controller macros: bus widths, watchdog width, hold time, register map and kick key
`ifndef RST_DEFS_SVH
`define RST_DEFS_SVH

// AXI4-Lite bus widths
`define RST_AXIL_ADDR_W 4
`define RST_AXIL_DATA_W 32

// Watchdog counter and timeout width
`define RST_WDT_W 16

// Minimum system reset width in clock cycles
`define RST_HOLD_CYCLES 8

// Register offsets
`define RST_ADDR_CTRL   4'h0
`define RST_ADDR_KICK   4'h4
`define RST_ADDR_COUNT  4'h8
`define RST_ADDR_STATUS 4'hC

// Key expected in the low half of a KICK write
`define RST_KICK_KEY 16'hA55A

`endif

// File: rtl/rst_csr_pkg.sv
// Register interface types: AXI4-Lite channel structs, write word union, watchdog control
`include "rst_defs.svh"

package rst_csr_pkg;

  localparam logic [1:0] AXIL_OKAY   = 2'b00;
  localparam logic [1:0] AXIL_SLVERR = 2'b10;

  // Master to slave
  typedef struct packed {
    logic                           awvalid;
    logic [`RST_AXIL_ADDR_W-1:0]    awaddr;
    logic                           wvalid;
    logic [`RST_AXIL_DATA_W-1:0]    wdata;
    logic [`RST_AXIL_DATA_W/8-1:0]  wstrb;
    logic                           bready;
    logic                           arvalid;
    logic [`RST_AXIL_ADDR_W-1:0]    araddr;
    logic                           rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                           awready;
    logic                           wready;
    logic                           bvalid;
    logic [1:0]                     bresp;
    logic                           arready;
    logic                           rvalid;
    logic [`RST_AXIL_DATA_W-1:0]    rdata;
    logic [1:0]                     rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic                                      enable;
    logic [`RST_AXIL_DATA_W-`RST_WDT_W-2:0]    rsvd;
    logic [`RST_WDT_W-1:0]                     timeout;
  } csr_ctrl_word_t;

  typedef struct packed {
    logic [`RST_AXIL_DATA_W-`RST_WDT_W-1:0]    rsvd;
    logic [`RST_WDT_W-1:0]                     key;
  } csr_kick_word_t;

  // Same write word, read as CTRL or as KICK depending on the address
  typedef union packed {
    csr_ctrl_word_t ctrl;
    csr_kick_word_t kick;
  } csr_wdata_u;

  typedef struct packed {
    logic                     enable;
    logic [`RST_WDT_W-1:0]    timeout;
    logic                     kick;
  } wdt_ctrl_t;

endpackage

// File: rtl/rst_cause_pkg.sv
// Reset cause types: cause encoding, request bits and sticky status

package rst_cause_pkg;

  // Lower code wins
  typedef enum logic [1:0] {
    CAUSE_PWR  = 2'd0,
    CAUSE_EXT  = 2'd1,
    CAUSE_WDT  = 2'd2,
    CAUSE_NONE = 2'd3
  } rst_cause_e;

  // Synchronized request sources
  typedef struct packed {
    logic pwr;
    logic ext;
    logic wdt;
  } rst_req_t;

  // Sticky record, cleared by software write-1-clear
  typedef struct packed {
    logic       pwr_seen;
    logic       ext_seen;
    logic       wdt_seen;
    rst_cause_e last_cause;
  } rst_status_t;

endpackage

// File: rtl/rst_csr_axil.sv
// AXI4-Lite register slave with CTRL, KICK, COUNT and STATUS registers
`timescale 1ns/1ps
`include "rst_defs.svh"

module rst_csr_axil
  import rst_csr_pkg::*, rst_cause_pkg::*;
(
  input  logic                   clk,
  input  logic                   ext_reset_buf2,
  input  axil_req_t              axil_req,
  output axil_rsp_t              axil_rsp,
  output wdt_ctrl_t              wdt_ctrl,
  input  logic [`RST_WDT_W-1:0]  count,
  input  rst_status_t            status,
  output logic [2:0]             status_clr
);

  logic                         awready_q;
  logic                         bvalid_q;
  logic [1:0]                   bresp_q;
  logic                         arready_q;
  logic                         rvalid_q;
  logic [`RST_AXIL_DATA_W-1:0]  rdata_q;
  logic                         ctrl_enable_q;
  logic [`RST_WDT_W-1:0]        ctrl_timeout_q;
  logic                         kick_q;
  logic [2:0]                   status_clr_q;

  csr_wdata_u                   wword;
  logic [`RST_AXIL_ADDR_W-1:0]  waddr;
  logic                         wr_fire;
  logic                         wr_err;
  logic                         rd_fire;
  logic [`RST_AXIL_DATA_W-1:0]  rd_word;

  assign wword   = axil_req.wdata;
  assign waddr   = axil_req.awaddr;
  assign wr_fire = awready_q & axil_req.awvalid & axil_req.wvalid;
  assign rd_fire = arready_q & axil_req.arvalid;

  // Rejected writes leave every register untouched
  always_comb begin
    wr_err = 1'b0;
    if (axil_req.wstrb != '1)
      wr_err = 1'b1;
    else if (waddr == `RST_ADDR_COUNT)
      wr_err = 1'b1;
    else if (waddr == `RST_ADDR_KICK && wword.kick.key != `RST_KICK_KEY)
      wr_err = 1'b1;
  end

  // Write channel, one transaction at a time
  always_ff @(posedge clk) begin
    if (ext_reset_buf2) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b0;
    end else if (wr_fire) begin
      awready_q <= 1'b0;
      bvalid_q  <= 1'b1;
    end else begin
      awready_q <= axil_req.awvalid & axil_req.wvalid & ~awready_q & ~bvalid_q;
      if (bvalid_q && axil_req.bready)
        bvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire)
      bresp_q <= wr_err ? AXIL_SLVERR : AXIL_OKAY;
  end

  always_ff @(posedge clk) begin
    if (ext_reset_buf2) begin
      ctrl_enable_q  <= 1'b0;
      ctrl_timeout_q <= '1;
      kick_q         <= 1'b0;
      status_clr_q   <= '0;
    end else begin
      if (wr_fire && !wr_err && waddr == `RST_ADDR_CTRL) begin
        ctrl_enable_q  <= wword.ctrl.enable;
        ctrl_timeout_q <= wword.ctrl.timeout;
      end
      // Single-cycle strobes
      kick_q <= wr_fire & ~wr_err & (waddr == `RST_ADDR_KICK);
      if (wr_fire && !wr_err && waddr == `RST_ADDR_STATUS)
        status_clr_q <= axil_req.wdata[2:0];
      else
        status_clr_q <= '0;
    end
  end

  // Read data mux, KICK reads as zero
  always_comb begin
    rd_word = '0;
    case (axil_req.araddr)
      `RST_ADDR_CTRL: begin
        rd_word[`RST_AXIL_DATA_W-1] = ctrl_enable_q;
        rd_word[`RST_WDT_W-1:0]     = ctrl_timeout_q;
      end
      `RST_ADDR_COUNT:
        rd_word[`RST_WDT_W-1:0] = count;
      `RST_ADDR_STATUS:
        rd_word[5:0] = {status.last_cause, 1'b0, status.wdt_seen,
                        status.ext_seen, status.pwr_seen};
      default:
        rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (ext_reset_buf2) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b0;
    end else if (rd_fire) begin
      arready_q <= 1'b0;
      rvalid_q  <= 1'b1;
    end else begin
      arready_q <= axil_req.arvalid & ~arready_q & ~rvalid_q;
      if (rvalid_q && axil_req.rready)
        rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire)
      rdata_q <= rd_word;
  end

  assign axil_rsp.awready = awready_q;
  assign axil_rsp.wready  = awready_q;
  assign axil_rsp.bvalid  = bvalid_q;
  assign axil_rsp.bresp   = bresp_q;
  assign axil_rsp.arready = arready_q;
  assign axil_rsp.rvalid  = rvalid_q;
  assign axil_rsp.rdata   = rdata_q;
  assign axil_rsp.rresp   = AXIL_OKAY;

  assign wdt_ctrl.enable  = ctrl_enable_q;
  assign wdt_ctrl.timeout = ctrl_timeout_q;
  assign wdt_ctrl.kick    = kick_q;
  assign status_clr       = status_clr_q;

  // Responses wait for the master with their payload frozen
  a_bvalid_hold: assert property (@(posedge clk) disable iff (ext_reset_buf2)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp));

  a_rvalid_hold: assert property (@(posedge clk) disable iff (ext_reset_buf2)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

// File: rtl/wdt_counter.sv
// Watchdog counter with enable, kick clear and timeout bite
`timescale 1ns/1ps
`include "rst_defs.svh"

module wdt_counter
  import rst_csr_pkg::*;
(
  input  logic                   clk,
  input  logic                   ext_reset_buf2,
  input  wdt_ctrl_t              wdt_ctrl,
  output logic [`RST_WDT_W-1:0]  count,
  output logic                   bite
);

  logic [`RST_WDT_W-1:0] count_q;
  logic                  at_timeout;

  // Zero timeout disables the bite
  assign at_timeout = wdt_ctrl.enable
                    && (wdt_ctrl.timeout != '0)
                    && (count_q == wdt_ctrl.timeout);

  always_ff @(posedge clk) begin
    if (ext_reset_buf2)
      count_q <= '0;
    else if (!wdt_ctrl.enable || wdt_ctrl.kick || at_timeout)
      count_q <= '0;
    else
      count_q <= count_q + 1'b1;
  end

  assign count = count_q;
  assign bite  = at_timeout;

  // Reaching a nonzero timeout takes at least one enabled cycle before it
  a_bite_enabled: assert property (@(posedge clk) disable iff (ext_reset_buf2)
    bite |-> wdt_ctrl.enable && $past(wdt_ctrl.enable));

endmodule

// File: rtl/rst_cause_arbiter.sv
// Pin synchronizers, priority cause encoder and sticky reset status
`timescale 1ns/1ps

module rst_cause_arbiter
  import rst_cause_pkg::*;
(
  input  logic         clk,
  input  logic         ext_reset_buf2,
  input  logic         pwr_reset_n,
  input  logic         ext_reset_n,
  input  logic         bite,
  input  logic [2:0]   status_clr,
  output logic         req,
  output rst_cause_e   reset_source,
  output rst_status_t  status
);

  logic [1:0]   pwr_sync;
  logic [1:0]   ext_sync;
  rst_req_t     req_now;
  rst_req_t     req_q;
  rst_cause_e   cause_now;
  rst_cause_e   source_q;
  rst_status_t  status_q;

  // Two flops per pin with the request stored active high
  always_ff @(posedge clk) begin
    if (ext_reset_buf2) begin
      pwr_sync <= '0;
      ext_sync <= '0;
    end else begin
      pwr_sync <= {pwr_sync[0], ~pwr_reset_n};
      ext_sync <= {ext_sync[0], ~ext_reset_n};
    end
  end

  always_comb begin
    req_now.pwr = pwr_sync[1];
    req_now.ext = ext_sync[1];
    req_now.wdt = bite;
    if (req_now.pwr)
      cause_now = CAUSE_PWR;
    else if (req_now.ext)
      cause_now = CAUSE_EXT;
    else if (req_now.wdt)
      cause_now = CAUSE_WDT;
    else
      cause_now = CAUSE_NONE;
  end

  always_ff @(posedge clk) begin
    if (ext_reset_buf2) begin
      req_q    <= '0;
      source_q <= CAUSE_NONE;
      status_q <= '{pwr_seen: 1'b0, ext_seen: 1'b0, wdt_seen: 1'b0, last_cause: CAUSE_NONE};
    end else begin
      req_q    <= req_now;
      source_q <= cause_now;
      // A new event overrides a clear in the same cycle
      status_q.pwr_seen <= (status_q.pwr_seen & ~status_clr[0]) | req_now.pwr;
      status_q.ext_seen <= (status_q.ext_seen & ~status_clr[1]) | req_now.ext;
      status_q.wdt_seen <= (status_q.wdt_seen & ~status_clr[2]) | req_now.wdt;
      if (|req_now)
        status_q.last_cause <= cause_now;
    end
  end

  assign req          = |req_q;
  assign reset_source = source_q;
  assign status       = status_q;

  a_req_source: assert property (@(posedge clk) disable iff (ext_reset_buf2)
    req == (reset_source != CAUSE_NONE));

endmodule

// File: rtl/rst_pulse_stretcher.sv
// System reset pulse stretcher with minimum hold width
`timescale 1ns/1ps
`include "rst_defs.svh"

module rst_pulse_stretcher #(
  parameter int unsigned HOLD_CYCLES = `RST_HOLD_CYCLES
) (
  input  logic clk,
  input  logic ext_reset_buf2,
  input  logic req,
  output logic system_reset
);

  localparam int unsigned HOLD_W = $clog2(HOLD_CYCLES + 1);

  logic [HOLD_W-1:0] hold_q;
  logic              sys_rst_q;

  // Reload while requested, drain afterwards
  always_ff @(posedge clk) begin
    if (ext_reset_buf2) begin
      hold_q    <= '0;
      sys_rst_q <= 1'b0;
    end else begin
      if (req)
        hold_q <= HOLD_W'(HOLD_CYCLES);
      else if (hold_q != '0)
        hold_q <= hold_q - 1'b1;
      sys_rst_q <= req | (hold_q != '0);
    end
  end

  assign system_reset = sys_rst_q;

  a_min_width: assert property (@(posedge clk) disable iff (ext_reset_buf2)
    $rose(system_reset) |-> system_reset [*HOLD_CYCLES]);

endmodule

// File: rtl/reset_ctrl_top.sv
// Reset controller top: register slave, watchdog, cause arbiter and reset stretcher
`timescale 1ns/1ps
`include "rst_defs.svh"

module reset_ctrl_top
  import rst_csr_pkg::*, rst_cause_pkg::*;
(
  input  logic        clk,
  input  logic        ext_reset_buf2,
  input  axil_req_t   axil_req,
  output axil_rsp_t   axil_rsp,
  input  logic        pwr_reset_n,
  input  logic        ext_reset_n,
  output logic        system_reset,
  output rst_cause_e  reset_source
);

  wdt_ctrl_t              wdt_ctrl;
  logic [`RST_WDT_W-1:0]  wdt_count;
  logic                   wdt_bite;
  rst_status_t            status;
  logic [2:0]             status_clr;
  logic                   rst_req;

  rst_csr_axil u_csr (
    .clk            (clk),
    .ext_reset_buf2 (ext_reset_buf2),
    .axil_req       (axil_req),
    .axil_rsp       (axil_rsp),
    .wdt_ctrl       (wdt_ctrl),
    .count          (wdt_count),
    .status         (status),
    .status_clr     (status_clr)
  );

  wdt_counter u_wdt (
    .clk            (clk),
    .ext_reset_buf2 (ext_reset_buf2),
    .wdt_ctrl       (wdt_ctrl),
    .count          (wdt_count),
    .bite           (wdt_bite)
  );

  rst_cause_arbiter u_arb (
    .clk            (clk),
    .ext_reset_buf2 (ext_reset_buf2),
    .pwr_reset_n    (pwr_reset_n),
    .ext_reset_n    (ext_reset_n),
    .bite           (wdt_bite),
    .status_clr     (status_clr),
    .req            (rst_req),
    .reset_source   (reset_source),
    .status         (status)
  );

  rst_pulse_stretcher #(
    .HOLD_CYCLES    (`RST_HOLD_CYCLES)
  ) u_stretch (
    .clk            (clk),
    .ext_reset_buf2 (ext_reset_buf2),
    .req            (rst_req),
    .system_reset   (system_reset)
  );

endmodule

// File: bench/tb_reset_ctrl.sv
// Reset controller testbench with clock, reset, AXI4-Lite tasks, case-file interpreter and checks
`timescale 1ns/1ps
`include "rst_defs.svh"

module tb_reset_ctrl
  import rst_csr_pkg::*, rst_cause_pkg::*;
();

  localparam int WAIT_LIMIT = 100;
  localparam int SEL_BVALID = 0;
  localparam int SEL_RVALID = 1;
  localparam int SEL_SYSRST = 2;

  logic        clk;
  logic        ext_reset_buf2;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic        pwr_reset_n;
  logic        ext_reset_n;
  logic        system_reset;
  rst_cause_e  reset_source;

  integer           seed;
  integer           fd;
  integer           code;
  integer           run_len;
  integer           last_width;
  rst_cause_e       seen_source;
  logic [31:0]      prev_count;
  logic [31:0]      rd_val;
  logic [7:0]       cmd;
  logic [8*200-1:0] rest_of_line;
  bit               done;

  reset_ctrl_top DUT (
    .clk            (clk),
    .ext_reset_buf2 (ext_reset_buf2),
    .axil_req       (axil_req),
    .axil_rsp       (axil_rsp),
    .pwr_reset_n    (pwr_reset_n),
    .ext_reset_n    (ext_reset_n),
    .system_reset   (system_reset),
    .reset_source   (reset_source)
  );

  always #20 clk = ~clk;

  task automatic stop_on_failure();
    $display("tests failed");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    stop_on_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
      stop_on_failure();
    end
  endtask

  // Advance one cycle and sample outputs on the falling edge
  task automatic tick();
    @(negedge clk);
    if (reset_source !== CAUSE_NONE)
      seen_source = reset_source;
    if (system_reset === 1'b1) begin
      run_len = run_len + 1;
    end else begin
      if (run_len != 0)
        last_width = run_len;
      run_len = 0;
    end
  endtask

  function automatic logic watched(input int sel);
    case (sel)
      SEL_BVALID: watched = axil_rsp.bvalid;
      SEL_RVALID: watched = axil_rsp.rvalid;
      default:    watched = system_reset;
    endcase
  endfunction

  task automatic wait_until(input int sel, input logic level, input int bound,
                            input string what);
    int n;
    n = 0;
    while (watched(sel) !== level) begin
      tick();
      n = n + 1;
      if (n > bound)
        report_error({"timeout waiting for ", what});
    end
  endtask

  // With hold > 0 the response is stalled and the request stays up as a second transfer
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [1:0] exp_bresp,
                           input integer hold);
    axil_req.awaddr  = addr;
    axil_req.wdata   = data;
    axil_req.wstrb   = strb;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    axil_req.bready  = (hold == 0);
    wait_until(SEL_BVALID, 1'b1, WAIT_LIMIT, "write response");
    check_value("bresp", exp_bresp, axil_rsp.bresp);
    if (hold > 0) begin
      repeat (hold) begin
        tick();
        check_value("bvalid", 1, axil_rsp.bvalid);
        check_value("awready", 0, axil_rsp.awready);
        check_value("wready", 0, axil_rsp.wready);
        check_value("bresp", exp_bresp, axil_rsp.bresp);
      end
      axil_req.bready = 1'b1;
      wait_until(SEL_BVALID, 1'b0, WAIT_LIMIT, "release of the first write response");
      wait_until(SEL_BVALID, 1'b1, WAIT_LIMIT, "second write response");
      check_value("bresp", exp_bresp, axil_rsp.bresp);
    end
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    tick();
  endtask

  task automatic axi_read(input logic [3:0] addr, input integer hold,
                          output logic [31:0] data);
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    axil_req.rready  = (hold == 0);
    wait_until(SEL_RVALID, 1'b1, WAIT_LIMIT, "read data");
    data = axil_rsp.rdata;
    check_value("rresp", AXIL_OKAY, axil_rsp.rresp);
    if (hold > 0) begin
      repeat (hold) begin
        tick();
        check_value("rvalid", 1, axil_rsp.rvalid);
        check_value("arready", 0, axil_rsp.arready);
        check_value("rdata", data, axil_rsp.rdata);
      end
      axil_req.rready = 1'b1;
      wait_until(SEL_RVALID, 1'b0, WAIT_LIMIT, "release of the first read response");
      wait_until(SEL_RVALID, 1'b1, WAIT_LIMIT, "second read data");
      check_value("rdata", data, axil_rsp.rdata);
    end
    axil_req.arvalid = 1'b0;
    tick();
  endtask

  // Idle gaps shrink by up to 3 cycles so kicks always land before the timeout
  task automatic kick_loop(input integer period, input integer kicks);
    integer idle;
    repeat (kicks) begin
      idle = period - ($random(seed) & 3);
      repeat (idle) begin
        tick();
        check_value("system_reset", 0, system_reset);
      end
      axi_write(`RST_ADDR_KICK, {16'h0000, `RST_KICK_KEY}, 4'hf, AXIL_OKAY, 0);
    end
  endtask

  task automatic run_command(input logic [7:0] c);
    logic [31:0] a0;
    logic [31:0] a1;
    logic [31:0] a2;
    logic [31:0] a3;
    logic [31:0] a4;
    integer      n;
    case (c)
      "#": n = $fgets(rest_of_line, fd);
      "W": begin
        n = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
        axi_write(a0[3:0], a1, a2[3:0], a3[1:0], a4);
      end
      "R": begin
        n = $fscanf(fd, "%h %h %h", a0, a1, a2);
        axi_read(a0[3:0], a2, rd_val);
        check_value($sformatf("rdata at 0x%h", a0[3:0]), a1, rd_val);
      end
      "N": begin
        axi_read(`RST_ADDR_COUNT, 0, rd_val);
        if (rd_val <= prev_count)
          report_error($sformatf("COUNT did not rise, %0d after %0d", rd_val, prev_count));
        prev_count = rd_val;
      end
      "P": begin
        n = $fscanf(fd, "%h %h", a0, a1);
        pwr_reset_n = a0[0];
        ext_reset_n = a1[0];
      end
      "K": begin
        n = $fscanf(fd, "%h %h", a0, a1);
        kick_loop(a0, a1);
      end
      "I": begin
        n = $fscanf(fd, "%h %h", a0, a1);
        repeat (a0) begin
          tick();
          check_value("system_reset", a1, system_reset);
        end
      end
      "E": begin
        n = $fscanf(fd, "%h %h", a0, a1);
        seen_source = CAUSE_NONE;
        wait_until(SEL_SYSRST, 1'b1, a1, "system_reset to rise");
        check_value("reset_source", a0, seen_source);
      end
      "H": begin
        n = $fscanf(fd, "%h %h", a0, a1);
        wait_until(SEL_SYSRST, 1'b0, a1, "system_reset to fall");
        if (last_width < a0)
          check_value("system_reset width", a0, last_width);
      end
      default: report_error($sformatf("unknown case command '%c'", c));
    endcase
  endtask

  initial begin
    seed           = 32'he98b_fc81;
    clk            = 1'b0;
    ext_reset_buf2 = 1'b1;
    axil_req       = '0;
    axil_req.wstrb = 4'hf;
    axil_req.bready = 1'b1;
    axil_req.rready = 1'b1;
    pwr_reset_n    = 1'b1;
    ext_reset_n    = 1'b1;
    run_len        = 0;
    last_width     = 0;
    seen_source    = CAUSE_NONE;
    prev_count     = '0;
    done           = 1'b0;
    repeat (8) tick();
    ext_reset_buf2 = 1'b0;
    fd = $fopen("bench/reset_cases.txt", "r");
    if (fd == 0)
      report_error("cannot open bench/reset_cases.txt");
    while (!done) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1)
        done = 1'b1;
      else
        run_command(cmd);
    end
    $fclose(fd);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: bench/reset_cases.txt
# Fields in hex. W addr data strb bresp hold, R addr rdata hold, N reads COUNT and expects a rise
# P pwr_n ext_n, K period kicks, I cycles system_reset, E cause bound, H min_width bound
R 0 0000ffff 0
R c 00000030 0
I 2 0
W 0 00001234 f 0 0
R 0 00001234 0
W 8 00000000 f 2 0
W 0 80000055 7 2 0
R 0 00001234 0
W 0 8000ffff f 0 0
I 14 0
N
W 4 00001234 f 2 0
N
W 0 0000ffff f 0 0
W 0 80000010 f 0 0
K 6 8
E 2 14
H 9 14
W 0 0000ffff f 0 0
R c 00000024 0
W c 00000007 f 0 0
R c 00000020 0
P 1 0
I 2 0
P 1 1
E 1 6
H a 14
P 1 0
E 1 6
I 14 1
P 1 1
H 1c 20
W c 00000007 f 0 0
R c 00000010 0
P 0 0
E 0 6
P 1 1
H c 14
R c 00000003 0
W c 00000002 f 0 0
R c 00000001 0
W 0 00004321 f 0 4
R 0 00004321 4

// File: tb.f
+incdir+include
rtl/rst_csr_pkg.sv
rtl/rst_cause_pkg.sv
rtl/rst_csr_axil.sv
rtl/wdt_counter.sv
rtl/rst_cause_arbiter.sv
rtl/rst_pulse_stretcher.sv
rtl/reset_ctrl_top.sv
bench/tb_reset_ctrl.sv

// File: Bender.yml
package:
  name: reset_ctrl

export_include_dirs:
  - include

sources:
  - rtl/rst_csr_pkg.sv
  - rtl/rst_cause_pkg.sv
  - rtl/rst_csr_axil.sv
  - rtl/wdt_counter.sv
  - rtl/rst_cause_arbiter.sv
  - rtl/rst_pulse_stretcher.sv
  - rtl/reset_ctrl_top.sv
  - target: simulation
    files:
      - bench/tb_reset_ctrl.sv
